// ==== Bender.yml ====
package:
  name: pe_tile_right

sources:
  - include_dirs:
      - .
    files:
      - fabric_pkg.sv
      - tile_cfg_if.sv
      - connect_box.sv
      - switch_box_right.sv
      - clb.sv
      - pe_tile_right.sv
  - target: test
    include_dirs:
      - .
    files:
      - pe_tile_right_checker.sv
      - tb_pe_tile_right.sv

// ==== clb.sv ====
`timescale 1ns/10ps
`default_nettype none

module clb (
	input logic clk,
	input logic rst_n,
	tile_cfg_if.block cfg,
	input logic in0,
	input logic in1,
	output logic out
);

	import fabric_pkg::*;

	clb_op_e op;
	logic result;

	// ######################################################################
	// Operation register
	// ######################################################################

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op <= CLB_AND;
		end else if (cfg.en_clb) begin
			op <= clb_op_e'(cfg.cfg_data[1:0]);
		end
	end

	always_comb begin
		case (op)
			CLB_AND: result = in0 & in1;
			CLB_OR: result = in0 | in1;
			CLB_XOR: result = in0 ^ in1;
			default: result = ~(in0 & in1);
		endcase
	end

	// Result appears one clock after the operands
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out <= 1'b0;
		end else begin
			out <= result;
		end
	end

endmodule

`default_nettype wire

// ==== connect_box.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fabric_defs.svh"

module connect_box (
	input logic clk,
	input logic rst_n,
	tile_cfg_if.block cfg,
	input logic sel_en,
	input fabric_pkg::track_t tracks,
	output logic block_out
);

	localparam int SEL_W = $clog2(`FAB_TRACKS);

	logic [SEL_W-1:0] sel;

	// ######################################################################
	// Track select register
	// ######################################################################

	// Enable comes from the tile, which knows which box this is
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel <= '0;
		end else if (sel_en) begin
			sel <= cfg.cfg_data[SEL_W-1:0];
		end
	end

	// ######################################################################
	// Operand selection
	// ######################################################################

	always_comb begin
		block_out = tracks[sel];
	end

endmodule

`default_nettype wire

// ==== fabric_defs.svh ====
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// ######################################################################
// Fabric geometry
// ######################################################################

// Tracks per routing side
`define FAB_TRACKS 4

// ######################################################################
// Configuration bus
// ######################################################################

// Address and data word width
`define FAB_CFG_W 32

// Lower part of the address selects the tile
`define FAB_TILE_ID_W 16

`endif

// ==== fabric_pkg.sv ====
`default_nettype none

`include "fabric_defs.svh"

package fabric_pkg;

	// One routing side, one bit per track
	typedef logic [`FAB_TRACKS-1:0] track_t;

	// Upper half names the block, lower half names the tile
	typedef struct packed {
		logic [`FAB_CFG_W-`FAB_TILE_ID_W-1:0] region;
		logic [`FAB_TILE_ID_W-1:0] tile;
	} cfg_addr_t;

	// Configuration targets inside a tile
	typedef enum logic [`FAB_CFG_W-`FAB_TILE_ID_W-1:0] {
		CFG_CLB = 4,
		CFG_CB1 = 5,
		CFG_CB0 = 6,
		CFG_SB = 7
	} cfg_region_e;

	// Logic block operations
	typedef enum logic [1:0] {
		CLB_AND = 2'd0,
		CLB_OR = 2'd1,
		CLB_XOR = 2'd2,
		CLB_NAND = 2'd3
	} clb_op_e;

endpackage

`default_nettype wire

// ==== pe_tile_right.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fabric_defs.svh"

module pe_tile_right (
	input logic clk,
	input logic rst_n,
	input logic [`FAB_CFG_W-1:0] config_addr,
	input logic [`FAB_CFG_W-1:0] config_data,
	input logic [`FAB_TILE_ID_W-1:0] tile_id,
	input fabric_pkg::track_t in_wire_0,
	input fabric_pkg::track_t in_wire_1,
	input fabric_pkg::track_t in_wire_2,
	input fabric_pkg::track_t in_wire_3,
	output fabric_pkg::track_t out_wire_1,
	output fabric_pkg::track_t out_wire_2,
	output fabric_pkg::track_t out_wire_3
);

	import fabric_pkg::*;

	cfg_addr_t addr_fields;
	logic tile_hit;

	logic op_0;
	logic op_1;
	logic pe_output;

	tile_cfg_if cfg_bus ();

	// ######################################################################
	// Configuration address decode
	// ######################################################################

	assign addr_fields = config_addr;
	assign tile_hit = (addr_fields.tile == tile_id);

	assign cfg_bus.cfg_data = config_data;

	// Plain strobes, one per block
	assign cfg_bus.en_sb = tile_hit && (addr_fields.region == CFG_SB);
	assign cfg_bus.en_cb0 = tile_hit && (addr_fields.region == CFG_CB0);
	assign cfg_bus.en_cb1 = tile_hit && (addr_fields.region == CFG_CB1);
	assign cfg_bus.en_clb = tile_hit && (addr_fields.region == CFG_CLB);

	// ######################################################################
	// Operand selection
	// ######################################################################

	connect_box cb0 (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg_bus.block),
		.sel_en(cfg_bus.en_cb0),
		.tracks(in_wire_0),
		.block_out(op_0)
	);

	connect_box cb1 (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg_bus.block),
		.sel_en(cfg_bus.en_cb1),
		.tracks(in_wire_1),
		.block_out(op_1)
	);

	// ######################################################################
	// Logic and routing
	// ######################################################################

	clb compute_block (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg_bus.block),
		.in0(op_0),
		.in1(op_1),
		.out(pe_output)
	);

	// Result re-enters the fabric through the switch box
	switch_box_right sb (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg_bus.block),
		.in_wire_0(in_wire_0),
		.in_wire_1(in_wire_1),
		.in_wire_2(in_wire_2),
		.in_wire_3(in_wire_3),
		.pe_output(pe_output),
		.out_wire_1(out_wire_1),
		.out_wire_2(out_wire_2),
		.out_wire_3(out_wire_3)
	);

endmodule

`default_nettype wire

// ==== pe_tile_right_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fabric_defs.svh"

module pe_tile_right_checker (
	input logic clk,
	input logic rst_n,
	input logic [`FAB_CFG_W-1:0] config_addr,
	input logic [`FAB_TILE_ID_W-1:0] tile_id,
	input logic en_sb,
	input logic en_cb0,
	input logic en_cb1,
	input logic en_clb,
	input fabric_pkg::track_t out_wire_1,
	input fabric_pkg::track_t out_wire_2,
	input fabric_pkg::track_t out_wire_3
);

	import fabric_pkg::*;

	cfg_addr_t addr_fields;
	logic [3:0] enables;
	int unsigned fail_count = 0;

	assign addr_fields = config_addr;
	assign enables = {en_sb, en_cb0, en_cb1, en_clb};

	// ######################################################################
	// Decode
	// ######################################################################

	a_enables_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(enables))
		else begin
			fail_count++;
			$error("More than one configuration enable is high");
		end

	a_foreign_tile: assert property (@(posedge clk) disable iff (!rst_n)
		(addr_fields.tile != tile_id) |-> (enables == 4'b0000))
		else begin
			fail_count++;
			$error("Enable raised for an address of another tile");
		end

	// ######################################################################
	// Outputs
	// ######################################################################

	a_outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({out_wire_1, out_wire_2, out_wire_3}))
		else begin
			fail_count++;
			$error("Unknown value on an output track");
		end

endmodule

bind pe_tile_right pe_tile_right_checker checker_i (
	.clk(clk),
	.rst_n(rst_n),
	.config_addr(config_addr),
	.tile_id(tile_id),
	.en_sb(cfg_bus.en_sb),
	.en_cb0(cfg_bus.en_cb0),
	.en_cb1(cfg_bus.en_cb1),
	.en_clb(cfg_bus.en_clb),
	.out_wire_1(out_wire_1),
	.out_wire_2(out_wire_2),
	.out_wire_3(out_wire_3)
);

`default_nettype wire

// ==== switch_box_right.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fabric_defs.svh"

module switch_box_right (
	input logic clk,
	input logic rst_n,
	tile_cfg_if.block cfg,
	input fabric_pkg::track_t in_wire_0,
	input fabric_pkg::track_t in_wire_1,
	input fabric_pkg::track_t in_wire_2,
	input fabric_pkg::track_t in_wire_3,
	input logic pe_output,
	output fabric_pkg::track_t out_wire_1,
	output fabric_pkg::track_t out_wire_2,
	output fabric_pkg::track_t out_wire_3
);

	import fabric_pkg::*;

	// Two code bits per track, three output sides
	localparam int CODE_W = 2;
	localparam int SIDE_CFG_W = CODE_W * `FAB_TRACKS;
	localparam int SB_CFG_W = 3 * SIDE_CFG_W;

	logic [SB_CFG_W-1:0] route_cfg;

	track_t in_side [0:3];
	track_t out_side [1:3];

	// ######################################################################
	// Routing register
	// ######################################################################

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			route_cfg <= '0;
		end else if (cfg.en_sb) begin
			route_cfg <= cfg.cfg_data[SB_CFG_W-1:0];
		end
	end

	assign in_side[0] = in_wire_0;
	assign in_side[1] = in_wire_1;
	assign in_side[2] = in_wire_2;
	assign in_side[3] = in_wire_3;

	// ######################################################################
	// Per-track multiplexers
	// ######################################################################

	// Codes 0..2 walk the other sides in increasing order, skipping s
	for (genvar s = 1; s <= 3; s++) begin : g_side
		localparam int SRC0 = 0;
		localparam int SRC1 = (s > 1) ? 1 : 2;
		localparam int SRC2 = (s > 2) ? 2 : 3;

		for (genvar t = 0; t < `FAB_TRACKS; t++) begin : g_track
			logic [CODE_W-1:0] code;

			assign code = route_cfg[(s - 1) * SIDE_CFG_W + CODE_W * t +: CODE_W];

			always_comb begin
				case (code)
					2'd0: out_side[s][t] = in_side[SRC0][t];
					2'd1: out_side[s][t] = in_side[SRC1][t];
					2'd2: out_side[s][t] = in_side[SRC2][t];
					default: out_side[s][t] = pe_output;
				endcase
			end
		end
	end

	// No side 0 output on the right edge
	assign out_wire_1 = out_side[1];
	assign out_wire_2 = out_side[2];
	assign out_wire_3 = out_side[3];

endmodule

`default_nettype wire

// ==== tb_pe_tile_right.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fabric_defs.svh"

module tb_pe_tile_right;

	import fabric_pkg::*;

	localparam int RESET_CYCLES = 3;
	localparam int RESET_TIMEOUT = 20;
	localparam int MAX_LINES = 1000;
	localparam logic [`FAB_TILE_ID_W-1:0] TILE_ID = 16'h0003;
	// Tile field 0 never addresses this tile
	localparam logic [`FAB_CFG_W-1:0] IDLE_ADDR = '0;

	logic clk = 1'b0;
	logic rst_n;
	logic [`FAB_CFG_W-1:0] config_addr;
	logic [`FAB_CFG_W-1:0] config_data;
	track_t in_wire_0;
	track_t in_wire_1;
	track_t in_wire_2;
	track_t in_wire_3;
	track_t out_wire_1;
	track_t out_wire_2;
	track_t out_wire_3;

	int fd;
	int scan_count;
	int line_count;
	int vector_count;
	logic [7:0] kind;
	logic [8*128-1:0] rest_of_line;
	logic [`FAB_CFG_W-1:0] file_addr;
	logic [`FAB_CFG_W-1:0] file_data;
	track_t vec_in [0:3];
	track_t vec_exp [1:3];

	pe_tile_right dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id(TILE_ID),
		.in_wire_0(in_wire_0),
		.in_wire_1(in_wire_1),
		.in_wire_2(in_wire_2),
		.in_wire_3(in_wire_3),
		.out_wire_1(out_wire_1),
		.out_wire_2(out_wire_2),
		.out_wire_3(out_wire_3)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

	// Bound assertions end the run at the next falling edge
	always @(negedge clk) begin
		if (dut_i.checker_i.fail_count != 0) begin
			$display("An assertion in the bound checker failed at %0t", $time);
			end_in_failure();
		end
	end

	// ######################################################################
	// Helpers
	// ######################################################################

	task automatic end_in_failure();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check(
		input string name,
		input logic [31:0] actual,
		input logic [31:0] expected
	);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h",
				$time, name, actual, expected);
			end_in_failure();
		end
	endtask

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			cycles++;
			if (cycles > RESET_TIMEOUT) begin
				$display("Reset was not released within %0d cycles", RESET_TIMEOUT);
				end_in_failure();
			end
		end
	endtask

	task automatic write_config(
		input logic [`FAB_CFG_W-1:0] addr,
		input logic [`FAB_CFG_W-1:0] data
	);
		@(posedge clk);
		config_addr <= addr;
		config_data <= data;
		// Strobe sampled here
		@(posedge clk);
		config_addr <= IDLE_ADDR;
		config_data <= '0;
	endtask

	task automatic apply_vector();
		@(posedge clk);
		in_wire_0 <= vec_in[0];
		in_wire_1 <= vec_in[1];
		in_wire_2 <= vec_in[2];
		in_wire_3 <= vec_in[3];
		// Logic block registers the new operands on the first edge
		@(posedge clk);
		@(posedge clk);
		@(negedge clk);
		check($sformatf("vector %0d out_wire_1", vector_count), out_wire_1, vec_exp[1]);
		check($sformatf("vector %0d out_wire_2", vector_count), out_wire_2, vec_exp[2]);
		check($sformatf("vector %0d out_wire_3", vector_count), out_wire_3, vec_exp[3]);
		vector_count++;
	endtask

	// ######################################################################
	// Main sequence
	// ######################################################################

	initial begin
		rst_n = 1'b0;
		config_addr = IDLE_ADDR;
		config_data = '0;
		in_wire_0 = '0;
		in_wire_1 = '0;
		in_wire_2 = '0;
		in_wire_3 = '0;
		line_count = 0;
		vector_count = 0;
		fd = $fopen("tile_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open tile_input.txt");
			end_in_failure();
		end
		wait_for_reset();
		scan_count = $fscanf(fd, " %c", kind);
		while (scan_count == 1) begin
			line_count++;
			if (line_count > MAX_LINES) begin
				$display("Input file has more than %0d lines", MAX_LINES);
				end_in_failure();
			end
			case (kind)
				"#": scan_count = $fgets(rest_of_line, fd);
				"C": begin
					scan_count = $fscanf(fd, "%h %h", file_addr, file_data);
					if (scan_count != 2) begin
						$display("Malformed configuration line %0d", line_count);
						end_in_failure();
					end
					write_config(file_addr, file_data);
				end
				"V": begin
					scan_count = $fscanf(fd, "%h %h %h %h %h %h %h",
						vec_in[0], vec_in[1], vec_in[2], vec_in[3],
						vec_exp[1], vec_exp[2], vec_exp[3]);
					if (scan_count != 7) begin
						$display("Malformed vector line %0d", line_count);
						end_in_failure();
					end
					apply_vector();
				end
				default: begin
					$display("Unknown line type on line %0d", line_count);
					end_in_failure();
				end
			endcase
			scan_count = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
		if (dut_i.checker_i.fail_count == 0 && vector_count > 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("%0d assertion failures, %0d vectors applied",
				dut_i.checker_i.fail_count, vector_count);
			end_in_failure();
		end
	end

endmodule

`default_nettype wire

// ==== tile_cfg_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fabric_defs.svh"

interface tile_cfg_if;

	// Shared data word, valid while any enable is high
	logic [`FAB_CFG_W-1:0] cfg_data;

	// One strobe per configurable block
	logic en_sb;
	logic en_cb0;
	logic en_cb1;
	logic en_clb;

	modport decoder (
		output cfg_data,
		output en_sb,
		output en_cb0,
		output en_cb1,
		output en_clb
	);

	modport block (
		input cfg_data,
		input en_sb,
		input en_cb0,
		input en_cb1,
		input en_clb
	);

endinterface

`default_nettype wire

// ==== tile_input.txt ====
# C <addr> <data> : one configuration write, hex
# V <in0> <in1> <in2> <in3> <exp1> <exp2> <exp3> : track vector and expected outputs, hex
V 5 a 3 c 5 5 5
V e 1 7 0 e e e
C 00070003 0055aa55
V 1 2 4 8 4 8 2
C 00070003 00924924
V 3 5 9 e 5 3 f
C 00070003 005700ff
C 00060003 00000002
C 00050003 00000001
C 00040003 00000002
V 4 0 0 0 f 4 1
V 4 2 0 0 0 4 2
C 00040003 00000001
C 00060003 00000003
C 00050003 00000000
V 8 0 0 0 f 8 1
V 7 6 0 0 0 7 6
C 00040003 00000003
C 00060003 00000001
C 00050003 00000003
V 2 8 0 0 0 2 8
V 2 5 0 0 f 2 5
C 00040003 00000000
C 00060003 00000000
C 00050003 00000002
V 1 b 0 0 0 1 a
C 00070004 00000000
C 00040002 00000003
C 00030003 00000000
V 1 4 0 0 f 1 5
C 00070003 00aaff55
V 1 4 6 9 6 f 6
C 00070003 00ff0000
V 1 4 6 9 1 1 f

// ==== verilog.f ====
+incdir+.
fabric_pkg.sv
tile_cfg_if.sv
connect_box.sv
switch_box_right.sv
clb.sv
pe_tile_right.sv
pe_tile_right_checker.sv
tb_pe_tile_right.sv
